// ==== rtl/chol_pkg.sv ====
`default_nettype none

package chol_pkg;

    // Matrix order is a power of two, so an element position is just {row, col}.
    localparam int IDX_BITS = 2;
    localparam int SIZE     = 1 << IDX_BITS;

    // Signed Q16.16 elements.
    localparam int WORD_BITS = 32;
    localparam int FRAC_BITS = 16;
    localparam int ACC_BITS  = 2 * WORD_BITS;  // Holds a full product.

    typedef logic signed [WORD_BITS-1:0] fix_t;
    typedef logic signed [ACC_BITS-1:0]  acc_t;
    typedef logic [IDX_BITS-1:0]         idx_t;

    // Row-major, element (i,j) sits at position i*SIZE+j.
    typedef fix_t [SIZE*SIZE-1:0] mat_t;

    // Unit latencies from start to done, one load cycle plus one cycle per result bit.
    localparam int SQRT_CYCLES = (WORD_BITS + FRAC_BITS) / 2 + 1;
    localparam int DIV_CYCLES  = WORD_BITS + FRAC_BITS + 1;

    // Element engine states.
    localparam logic [1:0] ENG_IDLE = 2'd0;
    localparam logic [1:0] ENG_MAC  = 2'd1;  // Subtract one product per cycle.
    localparam logic [1:0] ENG_RED  = 2'd2;  // Reduced value ready, launch a unit.
    localparam logic [1:0] ENG_WAIT = 2'd3;  // Wait for the root or the quotient.

endpackage

`default_nettype wire

// ==== rtl/elem_if.sv ====
`timescale 1ns/1ns
`default_nettype none

// One element request at a time between the sequencer and the engine.
interface elem_if;

    logic           start;  // One-cycle request.
    chol_pkg::idx_t row;    // Held until done.
    chol_pkg::idx_t col;
    logic           done;   // Element written, or radicand rejected.
    logic           fail;   // Valid with done.

    modport seq (
        output start,
        output row,
        output col,
        input  done,
        input  fail
    );

    modport eng (
        input  start,
        input  row,
        input  col,
        output done,
        output fail
    );

endinterface

`default_nettype wire

// ==== rtl/fix_sqrt.sv ====
`timescale 1ns/1ns
`default_nettype none

// Restoring square root, two radicand bits in and one root bit out per cycle.
// The radicand is scaled by 2^16 first, so the 24-bit root is Q16.16 again.
module fix_sqrt (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           start_i,
    input  chol_pkg::fix_t radicand_i,  // Positive.
    output logic           done_o,
    output chol_pkg::fix_t root_o
);

    logic [4:0]  cnt_q;      // Iterations left.
    logic [47:0] rad_q;      // Scaled radicand, consumed from the top.
    logic [25:0] rem_q;
    logic [23:0] root_q;
    logic [27:0] trial_in;
    logic [27:0] trial_sub;
    logic [27:0] diff;
    logic        fits;

    assign trial_in  = {rem_q, rad_q[47:46]};
    assign trial_sub = {2'b00, root_q, 2'b01};  // 4*root + 1.
    assign diff      = trial_in - trial_sub;
    assign fits      = (trial_in >= trial_sub);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q  <= '0;
            done_o <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (start_i) begin
                cnt_q <= 5'(chol_pkg::SQRT_CYCLES - 1);
            end else if (cnt_q != '0) begin
                cnt_q  <= cnt_q - 1'b1;
                done_o <= (cnt_q == 5'd1);  // Last bit lands with this edge.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            rad_q  <= {radicand_i, {chol_pkg::FRAC_BITS{1'b0}}};
            rem_q  <= '0;
            root_q <= '0;
        end else if (cnt_q != '0) begin
            rad_q <= {rad_q[45:0], 2'b00};
            if (fits) begin
                rem_q  <= diff[25:0];
                root_q <= {root_q[22:0], 1'b1};
            end else begin
                rem_q  <= trial_in[25:0];  // Smaller than 4*root + 1.
                root_q <= {root_q[22:0], 1'b0};
            end
        end
    end

    assign root_o = {8'b0, root_q};

endmodule

`default_nettype wire

// ==== rtl/fix_div.sv ====
`timescale 1ns/1ns
`default_nettype none

// Restoring divide on magnitudes, one quotient bit per cycle.
// Dividend is |num|*2^16, so the quotient comes out in Q16.16.
// Sign goes on at the end, which truncates toward zero.
module fix_div (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           start_i,
    input  chol_pkg::fix_t num_i,
    input  chol_pkg::fix_t den_i,
    output logic           done_o,
    output chol_pkg::fix_t quot_o
);

    logic [5:0]  cnt_q;      // Iterations left.
    logic [47:0] quo_q;      // Dividend shifts out at the top, quotient in at the bottom.
    logic [31:0] rem_q;
    logic [31:0] dvs_q;
    logic        neg_q;
    logic [31:0] num_mag;
    logic [31:0] den_mag;
    logic [32:0] shifted;
    logic [32:0] diff;
    logic        fits;

    // Magnitudes, -2^31 maps to 2^31 in unsigned form.
    assign num_mag = num_i[31] ? -num_i : num_i;
    assign den_mag = den_i[31] ? -den_i : den_i;

    assign shifted = {rem_q, quo_q[47]};
    assign diff    = shifted - {1'b0, dvs_q};
    assign fits    = (shifted >= {1'b0, dvs_q});

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q  <= '0;
            done_o <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (start_i) begin
                cnt_q <= 6'(chol_pkg::DIV_CYCLES - 1);
            end else if (cnt_q != '0) begin
                cnt_q  <= cnt_q - 1'b1;
                done_o <= (cnt_q == 6'd1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            quo_q <= {num_mag, {chol_pkg::FRAC_BITS{1'b0}}};
            rem_q <= '0;
            dvs_q <= den_mag;
            neg_q <= num_i[31] ^ den_i[31];
        end else if (cnt_q != '0) begin
            quo_q <= {quo_q[46:0], fits};
            // Remainder stays below the divisor either way.
            rem_q <= fits ? diff[31:0] : shifted[31:0];
        end
    end

    // Low word only, upper quotient bits are dropped.
    assign quot_o = neg_q ? -quo_q[31:0] : quo_q[31:0];

endmodule

`default_nettype wire

// ==== rtl/chol_traversal.sv ====
`timescale 1ns/1ns
`default_nettype none

// Walks the lower triangle row by row, (0,0) (1,0) (1,1) (2,0) and so on.
// Each row ends on its diagonal, so the run ends on (SIZE-1,SIZE-1).
module chol_traversal (
    input  logic clk,
    input  logic rst_n,
    input  logic start_i,
    elem_if.seq  seq,
    output logic busy_o,
    output logic done_o,
    output logic fail_o
);

    chol_pkg::idx_t row_q;
    chol_pkg::idx_t col_q;
    logic           start_q;
    logic           row_end;    // Current element is on the diagonal.
    logic           last_elem;

    assign row_end   = (col_q == row_q);
    assign last_elem = row_end && (row_q == chol_pkg::idx_t'(chol_pkg::SIZE - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row_q   <= '0;
            col_q   <= '0;
            start_q <= 1'b0;
            busy_o  <= 1'b0;
            done_o  <= 1'b0;
            fail_o  <= 1'b0;
        end else begin
            start_q <= 1'b0;
            done_o  <= 1'b0;
            if (!busy_o) begin
                // A start while busy is simply not looked at.
                if (start_i) begin
                    busy_o  <= 1'b1;
                    fail_o  <= 1'b0;
                    row_q   <= '0;
                    col_q   <= '0;
                    start_q <= 1'b1;  // First element is (0,0).
                end
            end else if (seq.done) begin
                if (seq.fail || last_elem) begin
                    busy_o <= 1'b0;
                    done_o <= 1'b1;
                    fail_o <= seq.fail;  // Sticky until the next start.
                end else begin
                    if (row_end) begin
                        row_q <= row_q + 1'b1;
                        col_q <= '0;
                    end else begin
                        col_q <= col_q + 1'b1;
                    end
                    start_q <= 1'b1;
                end
            end
        end
    end

    assign seq.start = start_q;
    assign seq.row   = row_q;
    assign seq.col   = col_q;

endmodule

`default_nettype wire

// ==== rtl/chol_element.sv ====
`timescale 1ns/1ns
`default_nettype none

// Computes one factor element per request.
//   l_rc = sqrt(a_rc - sum l_rk*l_ck)        for r == c
//   l_rc = (a_rc - sum l_rk*l_ck) / l_cc     for r > c
module chol_element (
    input  logic           clk,
    input  logic           rst_n,
    elem_if.eng            eng,
    input  logic           clear_i,
    input  chol_pkg::mat_t matrix_i,
    output chol_pkg::mat_t factor_o,
    output logic           sqrt_start_o,
    output chol_pkg::fix_t radicand_o,
    input  logic           sqrt_done_i,
    input  chol_pkg::fix_t root_i,
    output logic           div_start_o,
    output chol_pkg::fix_t num_o,
    output chol_pkg::fix_t den_o,
    input  logic           div_done_i,
    input  chol_pkg::fix_t quot_i
);

    logic [1:0]                      state_q;
    chol_pkg::idx_t                  k_q;
    chol_pkg::acc_t                  acc_q;
    chol_pkg::mat_t                  factor_q;
    logic                            done_q;
    logic                            fail_q;
    logic [2*chol_pkg::IDX_BITS-1:0] pos_rc;
    logic [2*chol_pkg::IDX_BITS-1:0] pos_rk;
    logic [2*chol_pkg::IDX_BITS-1:0] pos_ck;
    logic [2*chol_pkg::IDX_BITS-1:0] pos_cc;
    chol_pkg::acc_t                  prod;
    chol_pkg::acc_t                  acc_sh;
    chol_pkg::fix_t                  reduced;
    logic                            diag;

    assign pos_rc = {eng.row, eng.col};
    assign pos_rk = {eng.row, k_q};
    assign pos_ck = {eng.col, k_q};
    assign pos_cc = {eng.col, eng.col};
    assign diag   = (eng.row == eng.col);

    // Full product of two Q16.16 values, kept exact in the accumulator.
    assign prod = chol_pkg::acc_t'(factor_q[pos_rk]) * chol_pkg::acc_t'(factor_q[pos_ck]);

    // Back to Q16.16, arithmetic shift floors toward minus infinity.
    assign acc_sh  = acc_q >>> chol_pkg::FRAC_BITS;
    assign reduced = acc_sh[chol_pkg::WORD_BITS-1:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q  <= chol_pkg::ENG_IDLE;
            k_q      <= '0;
            factor_q <= '0;
            done_q   <= 1'b0;
            fail_q   <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (clear_i) begin
                factor_q <= '0;  // Upper triangle stays zero from here on.
            end
            case (state_q)
                chol_pkg::ENG_IDLE: begin
                    if (eng.start) begin
                        k_q     <= '0;
                        fail_q  <= 1'b0;
                        // Column 0 has no products to subtract.
                        state_q <= (eng.col == '0) ? chol_pkg::ENG_RED : chol_pkg::ENG_MAC;
                    end
                end
                chol_pkg::ENG_MAC: begin
                    k_q <= k_q + 1'b1;
                    if (k_q == eng.col - 1'b1) begin
                        state_q <= chol_pkg::ENG_RED;
                    end
                end
                chol_pkg::ENG_RED: begin
                    if (diag && reduced <= 0) begin
                        // Not positive definite. Nothing is written.
                        done_q  <= 1'b1;
                        fail_q  <= 1'b1;
                        state_q <= chol_pkg::ENG_IDLE;
                    end else begin
                        state_q <= chol_pkg::ENG_WAIT;
                    end
                end
                chol_pkg::ENG_WAIT: begin
                    // Only the unit that was started can answer.
                    if (sqrt_done_i || div_done_i) begin
                        factor_q[pos_rc] <= diag ? root_i : quot_i;
                        done_q           <= 1'b1;
                        state_q          <= chol_pkg::ENG_IDLE;
                    end
                end
                default: state_q <= chol_pkg::ENG_IDLE;
            endcase
        end
    end

    // Running value a_rc*2^16 minus the products so far.
    always_ff @(posedge clk) begin
        if (state_q == chol_pkg::ENG_IDLE && eng.start) begin
            acc_q <= chol_pkg::acc_t'(matrix_i[pos_rc]) <<< chol_pkg::FRAC_BITS;
        end else if (state_q == chol_pkg::ENG_MAC) begin
            acc_q <= acc_q - prod;
        end
    end

    assign sqrt_start_o = (state_q == chol_pkg::ENG_RED) && diag && (reduced > 0);
    assign div_start_o  = (state_q == chol_pkg::ENG_RED) && !diag;
    assign radicand_o   = reduced;
    assign num_o        = reduced;
    assign den_o        = factor_q[pos_cc];  // Diagonal of the column, already final.

    assign factor_o = factor_q;
    assign eng.done = done_q;
    assign eng.fail = fail_q;

endmodule

`default_nettype wire

// ==== rtl/chol_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module chol_top (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           start_i,
    input  chol_pkg::mat_t matrix_i,
    output chol_pkg::mat_t factor_o,
    output logic           busy_o,
    output logic           done_o,
    output logic           fail_o
);

    logic           accept;  // Start seen while idle.
    logic           sqrt_start;
    logic           sqrt_done;
    logic           div_start;
    logic           div_done;
    chol_pkg::fix_t radicand;
    chol_pkg::fix_t root;
    chol_pkg::fix_t num;
    chol_pkg::fix_t den;
    chol_pkg::fix_t quot;

    elem_if u_elem_if ();

    assign accept = start_i & ~busy_o;

    chol_traversal u_traversal (
        .clk     (clk),
        .rst_n   (rst_n),
        .start_i (start_i),
        .seq     (u_elem_if),
        .busy_o  (busy_o),
        .done_o  (done_o),
        .fail_o  (fail_o)
    );

    chol_element u_element (
        .clk          (clk),
        .rst_n        (rst_n),
        .eng          (u_elem_if),
        .clear_i      (accept),
        .matrix_i     (matrix_i),
        .factor_o     (factor_o),
        .sqrt_start_o (sqrt_start),
        .radicand_o   (radicand),
        .sqrt_done_i  (sqrt_done),
        .root_i       (root),
        .div_start_o  (div_start),
        .num_o        (num),
        .den_o        (den),
        .div_done_i   (div_done),
        .quot_i       (quot)
    );

    fix_sqrt u_sqrt (
        .clk        (clk),
        .rst_n      (rst_n),
        .start_i    (sqrt_start),
        .radicand_i (radicand),
        .done_o     (sqrt_done),
        .root_o     (root)
    );

    fix_div u_div (
        .clk     (clk),
        .rst_n   (rst_n),
        .start_i (div_start),
        .num_i   (num),
        .den_i   (den),
        .done_o  (div_done),
        .quot_o  (quot)
    );

endmodule

`default_nettype wire

// ==== bench/tb_clock.sv ====
`timescale 1ns/1ns
`default_nettype none

// Free-running clock for the testbench.
module tb_clock (
    output logic clk_o
);

    localparam int HALF_NS = 4;  // 8 ns period.

    initial begin
        clk_o = 1'b0;
        forever #(HALF_NS) clk_o = ~clk_o;
    end

endmodule

`default_nettype wire

// ==== bench/tb_chol.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_chol;

    localparam int S            = chol_pkg::SIZE;
    localparam int N_ENTRIES    = 13;
    localparam int N_ELEMS      = S * (S + 1) / 2;
    localparam int MATRIX_LIMIT = N_ELEMS * (S + chol_pkg::DIV_CYCLES + 2) + 40;
    localparam int RUN_LIMIT    = N_ENTRIES * (MATRIX_LIMIT + 10) + 20;

    typedef struct packed {
        chol_pkg::mat_t mat;
        logic           exp_fail;
        logic           restart;   // Pulse start_i again while busy.
    } entry_t;

    logic           clk;
    logic           rst_n;
    logic           start_i;
    chol_pkg::mat_t matrix_i;
    chol_pkg::mat_t factor_o;
    logic           busy_o;
    logic           done_o;
    logic           fail_o;
    entry_t         table_q [N_ENTRIES];
    integer         seed;
    int             fill_cnt  = 0;
    int             cycle_cnt = 0;

    tb_clock u_clock (.clk_o(clk));

    chol_top u_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .start_i  (start_i),
        .matrix_i (matrix_i),
        .factor_o (factor_o),
        .busy_o   (busy_o),
        .done_o   (done_o),
        .fail_o   (fail_o)
    );

    task automatic abort_run();
        $display("Verification failed");
        $fatal(1, "Run stopped at the first error.");
    endtask

    task automatic check_factor(input string name, input chol_pkg::mat_t got,
                                input chol_pkg::mat_t exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_fix(input string name, input chol_pkg::fix_t got,
                             input chol_pkg::fix_t exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    // Whole units to Q16.16.
    function automatic chol_pkg::fix_t to_fix(input int v);
        return chol_pkg::fix_t'(v) <<< chol_pkg::FRAC_BITS;
    endfunction

    function automatic chol_pkg::mat_t sym_put(input chol_pkg::mat_t m, input int i,
                                               input int j, input chol_pkg::fix_t v);
        m[i*S+j] = v;
        m[j*S+i] = v;
        return m;
    endfunction

    function automatic chol_pkg::mat_t diag_mat(input int d0, input int d1,
                                                input int d2, input int d3);
        chol_pkg::mat_t m;
        m = '0;
        m[0]     = to_fix(d0);
        m[S+1]   = to_fix(d1);
        m[2*S+2] = to_fix(d2);
        m[3*S+3] = to_fix(d3);
        return m;
    endfunction

    // B*B' + 4*I with B entries inside +-2.0.
    function automatic chol_pkg::mat_t random_spd();
        chol_pkg::fix_t b [S*S];
        chol_pkg::mat_t a;
        longint         acc;
        int             i;
        int             j;
        int             k;
        for (i = 0; i < S * S; i++) begin
            b[i] = chol_pkg::fix_t'($random(seed) % 131072);
        end
        for (i = 0; i < S; i++) begin
            for (j = 0; j < S; j++) begin
                acc = 0;
                for (k = 0; k < S; k++) begin
                    acc += longint'(b[i*S+k]) * longint'(b[j*S+k]);
                end
                a[i*S+j] = chol_pkg::fix_t'(acc >>> chol_pkg::FRAC_BITS);
            end
            a[i*S+i] = a[i*S+i] + to_fix(4);
        end
        return a;
    endfunction

    // Largest r with r*r <= x, found one bit at a time from the top.
    function automatic chol_pkg::fix_t isqrt(input longint x);
        longint r;
        longint t;
        int     b;
        r = 0;
        for (b = 23; b >= 0; b--) begin
            t = r | (longint'(1) <<< b);
            if (t * t <= x) r = t;
        end
        return chol_pkg::fix_t'(r);
    endfunction

    // Expected factor from the recurrences, stopping at a rejected radicand.
    function automatic chol_pkg::mat_t model_factor(input chol_pkg::mat_t a,
                                                    output logic fail);
        chol_pkg::mat_t l;
        chol_pkg::fix_t red;
        longint         acc;
        longint         q;
        int             i;
        int             j;
        int             k;
        l    = '0;
        fail = 1'b0;
        for (i = 0; i < S; i++) begin
            for (j = 0; j <= i; j++) begin
                if (!fail) begin
                    acc = longint'(a[i*S+j]) <<< chol_pkg::FRAC_BITS;
                    for (k = 0; k < j; k++) begin
                        acc -= longint'(l[i*S+k]) * longint'(l[j*S+k]);
                    end
                    red = chol_pkg::fix_t'(acc >>> chol_pkg::FRAC_BITS);  // Floor.
                    if (i == j && red <= 0) begin
                        fail = 1'b1;
                    end else if (i == j) begin
                        l[i*S+i] = isqrt(longint'(red) <<< chol_pkg::FRAC_BITS);
                    end else begin
                        q = (longint'(red) <<< chol_pkg::FRAC_BITS) / longint'(l[j*S+j]);
                        l[i*S+j] = chol_pkg::fix_t'(q);  // Low word, toward zero.
                    end
                end
            end
        end
        return l;
    endfunction

    task automatic add_entry(input chol_pkg::mat_t m, input logic f, input logic r);
        table_q[fill_cnt].mat      = m;
        table_q[fill_cnt].exp_fail = f;
        table_q[fill_cnt].restart  = r;
        fill_cnt++;
    endtask

    task automatic wait_done(input int limit);
        int n;
        n = 0;
        while (done_o !== 1'b1) begin
            if (n >= limit) begin
                $display("No done pulse arrived within %0d cycles of the start", limit);
                abort_run();
            end else begin
                @(negedge clk);
                n++;
            end
        end
    endtask

    task automatic apply_entry(input int n, input entry_t e);
        chol_pkg::mat_t exp_l;
        logic           exp_f;
        int             i;
        int             j;
        exp_l = model_factor(e.mat, exp_f);
        if (exp_f !== e.exp_fail) begin
            $display("Stimulus entry %0d disagrees with the model about failure", n);
            abort_run();
        end
        @(posedge clk);
        matrix_i <= e.mat;
        start_i  <= 1'b1;
        @(posedge clk);
        start_i <= 1'b0;
        @(negedge clk);
        check_flag("busy_o", busy_o, 1'b1);
        check_flag("fail_o", fail_o, 1'b0);  // Cleared by the start.
        check_factor("factor_o", factor_o, '0);
        if (e.restart) begin
            // Late enough that (0,0) is written, so an accepted restart would clear it.
            repeat (chol_pkg::SQRT_CYCLES + 5) @(posedge clk);
            start_i <= 1'b1;
            @(posedge clk);
            start_i <= 1'b0;
            @(negedge clk);
            check_flag("busy_o", busy_o, 1'b1);
            check_fix("factor_o[0][0]", factor_o[0], exp_l[0]);
        end
        wait_done(MATRIX_LIMIT);
        check_flag("busy_o", busy_o, 1'b0);
        check_flag("fail_o", fail_o, e.exp_fail);
        for (i = 0; i < S; i++) begin
            for (j = i + 1; j < S; j++) begin
                check_fix($sformatf("factor_o[%0d][%0d]", i, j), factor_o[i*S+j], '0);
            end
        end
        check_factor("factor_o", factor_o, exp_l);
        // Exactly one done pulse, result and flag held.
        repeat (3) begin
            @(negedge clk);
            check_flag("done_o", done_o, 1'b0);
            check_flag("busy_o", busy_o, 1'b0);
            check_flag("fail_o", fail_o, e.exp_fail);
        end
        check_factor("factor_o", factor_o, exp_l);
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= RUN_LIMIT) begin
            $display("Timeout, the run did not finish within %0d cycles", RUN_LIMIT);
            abort_run();
        end
    end

    initial begin
        chol_pkg::mat_t m_int;
        chol_pkg::mat_t m;
        int             r;
        seed     = 32'h96c5661a;
        rst_n    = 1'b0;
        start_i  = 1'b0;
        matrix_i = '0;

        m_int = diag_mat(5, 5, 6, 7);  // Diagonally dominant.
        m_int = sym_put(m_int, 1, 0, to_fix(2));
        m_int = sym_put(m_int, 3, 0, to_fix(2));
        m_int = sym_put(m_int, 2, 1, to_fix(1));
        m_int = sym_put(m_int, 3, 2, to_fix(2));
        add_entry(diag_mat(1, 1, 1, 1), 1'b0, 1'b0);
        add_entry(diag_mat(4, 9, 16, 25), 1'b0, 1'b0);
        add_entry(m_int, 1'b0, 1'b0);
        add_entry(diag_mat(4, 0, 9, 16), 1'b1, 1'b0);  // Zero at (1,1).
        m = '0;
        m = sym_put(m, 0, 0, 32'h0002_4000);
        m = sym_put(m, 1, 0, 32'h0000_c000);
        m = sym_put(m, 1, 1, 32'h0003_8000);
        m = sym_put(m, 2, 0, 32'hffff_8000);
        m = sym_put(m, 2, 1, 32'h0001_4000);
        m = sym_put(m, 2, 2, 32'h0004_0000);
        m = sym_put(m, 3, 0, 32'h0000_2000);
        m = sym_put(m, 3, 1, 32'hffff_0000);
        m = sym_put(m, 3, 2, 32'h0000_4ccd);
        m = sym_put(m, 3, 3, 32'h0005_0000);
        add_entry(m, 1'b0, 1'b0);
        m = diag_mat(1, 4, 1, 1);
        m = sym_put(m, 1, 0, to_fix(2));  // a_11 equals l_10 squared.
        add_entry(m, 1'b1, 1'b0);
        add_entry(m_int, 1'b0, 1'b1);
        for (r = 0; r < 6; r++) begin
            add_entry(random_spd(), 1'b0, r == 2);
        end

        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_flag("busy_o", busy_o, 1'b0);
        check_flag("done_o", done_o, 1'b0);
        check_flag("fail_o", fail_o, 1'b0);
        check_factor("factor_o", factor_o, '0);

        for (r = 0; r < N_ENTRIES; r++) begin
            apply_entry(r, table_q[r]);
        end
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
rtl/chol_pkg.sv
rtl/elem_if.sv
rtl/fix_sqrt.sv
rtl/fix_div.sv
rtl/chol_traversal.sv
rtl/chol_element.sv
rtl/chol_top.sv
bench/tb_clock.sv
bench/tb_chol.sv
